// File: hdl/timebase_defines.svh
`ifndef TIMEBASE_DEFINES_SVH
`define TIMEBASE_DEFINES_SVH

// channel count and datapath widths.
`define TB_NUM_CH     4
`define TB_DIV_WIDTH  24
`define TB_CNT_WIDTH  16
`define TB_ADDR_WIDTH 8

// divisor loaded at reset, gives a toggle every 10 cycles.
`define TB_DIV_RESET  9

// register map, one 32-bit word per register.
`define TB_CTRL_ADDR  8'h00
`define TB_DIV_BASE   8'h10
`define TB_CNT_BASE   8'h20

`endif

// File: hdl/timebase_pkg.sv
`include "timebase_defines.svh"

package timebase_pkg;

    // divisor of one channel, toggle period is divisor + 1 cycles.
    typedef logic [`TB_DIV_WIDTH-1:0] div_t;

    // wrapping tick count of one channel.
    typedef logic [`TB_CNT_WIDTH-1:0] cnt_t;

    // AXI response codes in use.
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

endpackage

// File: hdl/tick_divider.sv
`timescale 1ns/1ps

module tick_divider (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               enable,
    input  timebase_pkg::div_t divisor,
    input  logic               restart,
    output logic               tick,
    output logic               clk_out
);

    timebase_pkg::div_t cnt;
    timebase_pkg::div_t cnt_next;
    logic               at_end;
    logic               clk_next;

    // >= so a lowered divisor cannot strand the counter above it.
    assign at_end = (cnt >= divisor);

    always_comb begin
        if (!enable || restart || at_end) begin
            cnt_next = '0;
        end else begin
            cnt_next = cnt + 1'b1;
        end
    end

    // restart keeps the current level and disable parks it low.
    always_comb begin
        if (!enable) begin
            clk_next = 1'b0;
        end else if (!restart && at_end) begin
            clk_next = ~clk_out;
        end else begin
            clk_next = clk_out;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            tick    <= 1'b0;
            clk_out <= 1'b0;
        end else begin
            cnt     <= cnt_next;
            tick    <= enable && !restart && at_end;
            clk_out <= clk_next;
        end
    end

    a_quiet_when_off: assert property (@(posedge clk) disable iff (!rst_n)
        !enable |=> !tick && !clk_out);

endmodule

// File: hdl/tick_monitor.sv
`timescale 1ns/1ps
`include "timebase_defines.svh"

module tick_monitor (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`TB_NUM_CH-1:0] tick,
    input  logic [`TB_NUM_CH-1:0] cnt_clear,
    output timebase_pkg::cnt_t    tick_count [`TB_NUM_CH]
);

    genvar i;

    generate
        for (i = 0; i < `TB_NUM_CH; i++) begin : g_ch
            // clear wins over a tick in the same cycle.
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    tick_count[i] <= '0;
                end else if (cnt_clear[i]) begin
                    tick_count[i] <= '0;
                end else if (tick[i]) begin
                    tick_count[i] <= tick_count[i] + 1'b1;
                end
            end

            a_clear_zero: assert property (@(posedge clk) disable iff (!rst_n)
                cnt_clear[i] |=> (tick_count[i] == '0));
        end
    endgenerate

endmodule

// File: hdl/timebase_regs.sv
`timescale 1ns/1ps
`include "timebase_defines.svh"

module timebase_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [`TB_ADDR_WIDTH-1:0]    awaddr,
    input  logic                         wvalid,
    output logic                         wready,
    input  logic [31:0]                  wdata,
    input  logic [3:0]                   wstrb,
    output logic                         bvalid,
    input  logic                         bready,
    output timebase_pkg::resp_e          bresp,
    input  logic                         arvalid,
    output logic                         arready,
    input  logic [`TB_ADDR_WIDTH-1:0]    araddr,
    output logic                         rvalid,
    input  logic                         rready,
    output logic [31:0]                  rdata,
    output timebase_pkg::resp_e          rresp,
    output logic [`TB_NUM_CH-1:0]        ch_enable,
    output timebase_pkg::div_t           ch_divisor [`TB_NUM_CH],
    output logic [`TB_NUM_CH-1:0]        ch_restart,
    output logic [`TB_NUM_CH-1:0]        cnt_clear,
    input  timebase_pkg::cnt_t           tick_count [`TB_NUM_CH]
);

    logic                  wr_en;
    logic                  rd_en;
    logic                  wr_ctrl;
    logic                  rd_ctrl;
    logic [`TB_NUM_CH-1:0] wr_div;
    logic [`TB_NUM_CH-1:0] wr_cnt;
    logic                  wr_hit;
    logic                  rd_hit;
    logic [31:0]           rd_val;

    // address and data are taken together, only once the last response is gone.
    assign wr_en   = awvalid && wvalid && !bvalid;
    assign awready = wr_en;
    assign wready  = wr_en;

    assign rd_en   = arvalid && !rvalid;
    assign arready = rd_en;

    // write decode.
    always_comb begin
        wr_ctrl = (awaddr == `TB_CTRL_ADDR);
        for (int i = 0; i < `TB_NUM_CH; i++) begin
            wr_div[i] = (awaddr == `TB_ADDR_WIDTH'(`TB_DIV_BASE + 4 * i));
            wr_cnt[i] = (awaddr == `TB_ADDR_WIDTH'(`TB_CNT_BASE + 4 * i));
        end
        wr_hit = wr_ctrl || (|wr_div) || (|wr_cnt);
    end

    // read decode and data mux, unmapped reads return zero.
    always_comb begin
        rd_ctrl = (araddr == `TB_CTRL_ADDR);
        rd_hit  = rd_ctrl;
        rd_val  = rd_ctrl ? 32'(ch_enable) : '0;
        for (int i = 0; i < `TB_NUM_CH; i++) begin
            if (araddr == `TB_ADDR_WIDTH'(`TB_DIV_BASE + 4 * i)) begin
                rd_hit = 1'b1;
                rd_val = 32'(ch_divisor[i]);
            end
            if (araddr == `TB_ADDR_WIDTH'(`TB_CNT_BASE + 4 * i)) begin
                rd_hit = 1'b1;
                rd_val = 32'(tick_count[i]);
            end
        end
    end

    // enables and divisors.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ch_enable <= '0;
            for (int i = 0; i < `TB_NUM_CH; i++) begin
                ch_divisor[i] <= `TB_DIV_WIDTH'(`TB_DIV_RESET);
            end
        end else if (wr_en) begin
            // upper control bits are reserved.
            if (wr_ctrl) begin
                ch_enable <= wdata[`TB_NUM_CH-1:0];
            end
            for (int i = 0; i < `TB_NUM_CH; i++) begin
                if (wr_div[i]) begin
                    ch_divisor[i] <= wdata[`TB_DIV_WIDTH-1:0];
                end
            end
        end
    end

    // one-cycle side effects of a write.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ch_restart <= '0;
            cnt_clear  <= '0;
        end else begin
            ch_restart <= wr_en ? wr_div : '0;
            cnt_clear  <= wr_en ? wr_cnt : '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_en) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_en) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            bresp <= wr_hit ? timebase_pkg::OKAY : timebase_pkg::SLVERR;
        end
        if (rd_en) begin
            rdata <= rd_val;
            rresp <= rd_hit ? timebase_pkg::OKAY : timebase_pkg::SLVERR;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid);

    a_restart_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (|ch_restart) |=> (ch_restart == '0));

    a_clear_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (|cnt_clear) |=> (cnt_clear == '0));

endmodule

// File: hdl/timebase_top.sv
`timescale 1ns/1ps
`include "timebase_defines.svh"

module timebase_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`TB_ADDR_WIDTH-1:0] awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    output logic                      bvalid,
    input  logic                      bready,
    output timebase_pkg::resp_e       bresp,
    input  logic                      arvalid,
    output logic                      arready,
    input  logic [`TB_ADDR_WIDTH-1:0] araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [31:0]               rdata,
    output timebase_pkg::resp_e       rresp,
    output logic [`TB_NUM_CH-1:0]     clk_out,
    output logic [`TB_NUM_CH-1:0]     tick
);

    logic [`TB_NUM_CH-1:0] ch_enable;
    logic [`TB_NUM_CH-1:0] ch_restart;
    logic [`TB_NUM_CH-1:0] cnt_clear;
    timebase_pkg::div_t    ch_divisor [`TB_NUM_CH];
    timebase_pkg::cnt_t    tick_count [`TB_NUM_CH];

    timebase_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .ch_enable  (ch_enable),
        .ch_divisor (ch_divisor),
        .ch_restart (ch_restart),
        .cnt_clear  (cnt_clear),
        .tick_count (tick_count)
    );

    genvar i;

    generate
        for (i = 0; i < `TB_NUM_CH; i++) begin : g_div
            tick_divider u_div (
                .clk     (clk),
                .rst_n   (rst_n),
                .enable  (ch_enable[i]),
                .divisor (ch_divisor[i]),
                .restart (ch_restart[i]),
                .tick    (tick[i]),
                .clk_out (clk_out[i])
            );
        end
    endgenerate

    tick_monitor u_mon (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .cnt_clear  (cnt_clear),
        .tick_count (tick_count)
    );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 8 ns period.
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset spans the first two rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: verif/tb_timebase.sv
`timescale 1ns/1ps
`include "timebase_defines.svh"

module tb_timebase;

    localparam int TIMEOUT = 4000;

    logic                      clk;
    logic                      rst_n;
    logic                      awvalid;
    logic                      awready;
    logic [`TB_ADDR_WIDTH-1:0] awaddr;
    logic                      wvalid;
    logic                      wready;
    logic [31:0]               wdata;
    logic [3:0]                wstrb;
    logic                      bvalid;
    logic                      bready;
    timebase_pkg::resp_e       bresp;
    logic                      arvalid;
    logic                      arready;
    logic [`TB_ADDR_WIDTH-1:0] araddr;
    logic                      rvalid;
    logic                      rready;
    logic [31:0]               rdata;
    timebase_pkg::resp_e       rresp;
    logic [`TB_NUM_CH-1:0]     clk_out;
    logic [`TB_NUM_CH-1:0]     tick;

    int                    errors;
    int                    timeouts;
    int                    cycle;
    int                    last_hs;
    logic [31:0]           lfsr_state;
    timebase_pkg::div_t    exp_div [`TB_NUM_CH];
    int                    tick_total [`TB_NUM_CH];
    int                    edge_cnt [`TB_NUM_CH];
    int                    last_edge [`TB_NUM_CH];
    int                    first_edge [`TB_NUM_CH];
    logic [`TB_NUM_CH-1:0] prev_clk;
    logic [`TB_NUM_CH-1:0] edge_chk;
    logic [`TB_NUM_CH-1:0] period_chk;
    logic [`TB_NUM_CH-1:0] quiet_chk;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    timebase_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .clk_out (clk_out),
        .tick    (tick)
    );

    task automatic note_mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t ns: %s", $time, msg);
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("Timed out at %0t ns while waiting for %s", $time, what);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken.
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [7:0] div_addr(input int ch);
        return 8'(`TB_DIV_BASE + 4 * ch);
    endfunction

    function automatic logic [7:0] cnt_addr(input int ch);
        return 8'(`TB_CNT_BASE + 4 * ch);
    endfunction

    // port monitor samples 2 ns after each rising edge.
    always begin
        int gap;
        @(posedge clk);
        #2;
        cycle = cycle + 1;
        for (int i = 0; i < `TB_NUM_CH; i++) begin
            if (tick[i]) begin
                tick_total[i] = tick_total[i] + 1;
            end
            if (clk_out[i] != prev_clk[i]) begin
                if (edge_chk[i]) begin
                    assert (tick[i]) else
                        note_mismatch($sformatf("clk_out[%0d] toggled without tick", i));
                end
                if (period_chk[i] && edge_cnt[i] > 0) begin
                    gap = cycle - last_edge[i];
                    assert (gap == int'(exp_div[i]) + 1) else
                        note_mismatch($sformatf("ch %0d gap %0d, expected %0d",
                                                i, gap, int'(exp_div[i]) + 1));
                end
                if (edge_cnt[i] == 0) begin
                    first_edge[i] = cycle;
                end
                edge_cnt[i]  = edge_cnt[i] + 1;
                last_edge[i] = cycle;
            end else begin
                assert (!tick[i]) else
                    note_mismatch($sformatf("tick[%0d] without clk_out toggle", i));
            end
            if (quiet_chk[i]) begin
                assert (!clk_out[i] && !tick[i]) else
                    note_mismatch($sformatf("ch %0d active while disabled", i));
            end
        end
        prev_clk = clk_out;
    end

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input timebase_pkg::resp_e exp_resp);
        int n;
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        bready  = 1'b1;
        n = 0;
        #1;
        while (!(awready && wready) && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        // handshake lands on the next rising edge.
        last_hs = cycle + 1;
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (n >= TIMEOUT) begin
            note_timeout("awready and wready");
        end else begin
            n = 0;
            while (!bvalid && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (n >= TIMEOUT) begin
                note_timeout("bvalid");
            end else begin
                assert (bresp == exp_resp) else
                    note_mismatch($sformatf("write 0x%02h bresp %0d, expected %0d",
                                            addr, bresp, exp_resp));
            end
        end
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] exp_data,
                              input timebase_pkg::resp_e exp_resp);
        int n;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b1;
        n = 0;
        #1;
        while (!arready && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        @(negedge clk);
        arvalid = 1'b0;
        if (n >= TIMEOUT) begin
            note_timeout("arready");
        end else begin
            n = 0;
            while (!rvalid && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (n >= TIMEOUT) begin
                note_timeout("rvalid");
            end else begin
                assert (rdata == exp_data && rresp == exp_resp) else
                    note_mismatch($sformatf("read 0x%02h got 0x%08h/%0d, expected 0x%08h/%0d",
                                            addr, rdata, rresp, exp_data, exp_resp));
            end
        end
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic read_all_regs(input logic [31:0] exp_ctrl);
        read_check(`TB_CTRL_ADDR, exp_ctrl, timebase_pkg::OKAY);
        for (int i = 0; i < `TB_NUM_CH; i++) begin
            read_check(div_addr(i), 32'(exp_div[i]), timebase_pkg::OKAY);
            read_check(cnt_addr(i), 32'(tick_total[i]) & 32'h0000_ffff, timebase_pkg::OKAY);
        end
    endtask

    task automatic wait_edges(input int ch, input int count);
        int n;
        n = 0;
        while (edge_cnt[ch] < count && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            note_timeout($sformatf("clk_out[%0d] edges", ch));
        end
    endtask

    task automatic test_reset_state();
        read_all_regs(32'h0);
        repeat (20) @(negedge clk);
    endtask

    task automatic test_divider_period();
        quiet_chk = '0;
        for (int i = 0; i < `TB_NUM_CH; i++) begin
            exp_div[i] = timebase_pkg::div_t'(rand_bits(5) + 2);
            axi_write(div_addr(i), 32'(exp_div[i]), timebase_pkg::OKAY);
            edge_cnt[i] = 0;
        end
        period_chk = '1;
        edge_chk   = '1;
        axi_write(`TB_CTRL_ADDR, 32'hf, timebase_pkg::OKAY);
        for (int i = 0; i < `TB_NUM_CH; i++) begin
            wait_edges(i, 6);
        end
        period_chk = '0;
    endtask

    task automatic test_tick_counting();
        repeat (300) @(negedge clk);
        // a disable drops clk_out without a tick.
        edge_chk = '0;
        axi_write(`TB_CTRL_ADDR, 32'h0, timebase_pkg::OKAY);
        repeat (4) @(negedge clk);
        for (int i = 0; i < `TB_NUM_CH; i++) begin
            assert (tick_total[i] > 0) else
                note_mismatch($sformatf("no ticks seen on ch %0d", i));
        end
        read_all_regs(32'h0);
    endtask

    task automatic test_clear();
        axi_write(cnt_addr(1), 32'h0, timebase_pkg::OKAY);
        tick_total[1] = 0;
        read_all_regs(32'h0);
    endtask

    task automatic test_disable_restart();
        int hs;
        quiet_chk[2] = 1'b1;
        repeat (60) @(negedge clk);
        exp_div[2] = timebase_pkg::div_t'(rand_bits(5) + 2);
        axi_write(div_addr(2), 32'(exp_div[2]), timebase_pkg::OKAY);
        quiet_chk[2]  = 1'b0;
        edge_cnt[2]   = 0;
        period_chk[2] = 1'b1;
        axi_write(`TB_CTRL_ADDR, 32'h4, timebase_pkg::OKAY);
        hs = last_hs;
        wait_edges(2, 3);
        // counter runs 0..divisor from the enable edge.
        assert (first_edge[2] == hs + int'(exp_div[2]) + 1) else
            note_mismatch($sformatf("first edge at cycle %0d, expected %0d",
                                    first_edge[2], hs + int'(exp_div[2]) + 1));
        period_chk[2] = 1'b0;
        axi_write(`TB_CTRL_ADDR, 32'h0, timebase_pkg::OKAY);
        repeat (4) @(negedge clk);
    endtask

    task automatic test_bad_address();
        quiet_chk = '1;
        axi_write(8'h0c, 32'hffff_ffff, timebase_pkg::SLVERR);
        axi_write(8'h30, 32'h0000_0001, timebase_pkg::SLVERR);
        read_check(8'h0c, 32'h0, timebase_pkg::SLVERR);
        read_check(8'h34, 32'h0, timebase_pkg::SLVERR);
        // reserved control bits.
        axi_write(`TB_CTRL_ADDR, 32'hffff_fff0, timebase_pkg::OKAY);
        read_all_regs(32'h0);
    endtask

    initial begin
        int n;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        wstrb      = 4'hf;
        bready     = 1'b0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        errors     = 0;
        timeouts   = 0;
        cycle      = 0;
        last_hs    = 0;
        lfsr_state = 32'hac224180;
        prev_clk   = '0;
        edge_chk   = '0;
        period_chk = '0;
        quiet_chk  = '1;
        for (int i = 0; i < `TB_NUM_CH; i++) begin
            exp_div[i]    = timebase_pkg::div_t'(`TB_DIV_RESET);
            tick_total[i] = 0;
            edge_cnt[i]   = 0;
            last_edge[i]  = 0;
            first_edge[i] = 0;
        end
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (n >= 20) begin
            note_timeout("reset release");
        end
        test_reset_state();
        test_divider_period();
        test_tick_counting();
        test_clear();
        test_disable_restart();
        test_bad_address();
        $display("Check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+hdl
hdl/timebase_pkg.sv
hdl/tick_divider.sv
hdl/tick_monitor.sv
hdl/timebase_regs.sv
hdl/timebase_top.sv
verif/tb_clock.sv
verif/tb_timebase.sv

// File: Makefile
VERILATOR  := verilator
TOP        := tb_timebase
LINT_TOP   := timebase_top
FILELIST   := src.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
